/* hw/lcd_pkg.sv */
// display controller shared definitions
package lcd_pkg;

    // transfer limits
    localparam logic [2:0] max_par_bytes = 3'd4;  // widest parameter burst
    localparam int unsigned pause_w = 24;
    localparam logic [pause_w-1:0] pause_cycles = 24'd12;  // csx-high settle time

    // display opcodes
    localparam logic [7:0] op_nop       = 8'h00;
    localparam logic [7:0] op_swreset   = 8'h01;
    localparam logic [7:0] op_sleep_in  = 8'h10;
    localparam logic [7:0] op_sleep_out = 8'h11;
    localparam logic [7:0] op_disp_off  = 8'h28;
    localparam logic [7:0] op_disp_on   = 8'h29;
    localparam logic [7:0] op_caset     = 8'h2A;
    localparam logic [7:0] op_paset     = 8'h2B;
    localparam logic [7:0] op_ramwr     = 8'h2C;
    localparam logic [7:0] op_ramrd     = 8'h2E;
    localparam logic [7:0] op_madctl    = 8'h36;
    localparam logic [7:0] op_pixfmt    = 8'h3A;

    // command view of the cpu word
    typedef struct packed {
        logic [19:0] rsvd;
        logic [3:0]  count_override;  // used for unknown opcodes only
        logic [7:0]  opcode;
    } mmio_cmd_t;

    // one bus word, read either as a command or as four parameter bytes
    typedef union packed {
        mmio_cmd_t       cmd;
        logic [3:0][7:0] par;  // par[3] goes out first
    } mmio_word_u;

    // one transfer from the front end to the sequencer
    typedef struct packed {
        logic [7:0]  opcode;
        logic [2:0]  param_count;
        logic [31:0] params;
        logic        pause;
    } lcd_xfer_t;

    // panel side pins
    typedef struct packed {
        logic [7:0] data;
        logic       csx;
        logic       dcx;  // 0 command, 1 parameter
        logic       wrx;
        logic       rdx;
    } lcd_bus_t;

endpackage

/* hw/lcd_cmd_table.sv */
// opcode to parameter count decode
`timescale 1ns/10ps

module lcd_cmd_table (
    input  logic [7:0] opcode,
    input  logic [3:0] count_override,
    output logic [2:0] param_count,
    output logic       pause
);

    logic [2:0] override_capped;

    // unknown opcodes take the cpu field, never more than the burst limit
    always_comb begin
        if (count_override > {1'b0, lcd_pkg::max_par_bytes}) begin
            override_capped = lcd_pkg::max_par_bytes;
        end else begin
            override_capped = count_override[2:0];
        end
    end

    always_comb begin
        case (opcode)
            lcd_pkg::op_caset,
            lcd_pkg::op_paset: begin
                param_count = 3'd4;  // start and end, two bytes each
            end
            lcd_pkg::op_ramwr,
            lcd_pkg::op_ramrd: begin
                param_count = 3'd2;
            end
            lcd_pkg::op_madctl,
            lcd_pkg::op_pixfmt: begin
                param_count = 3'd1;
            end
            lcd_pkg::op_nop,
            lcd_pkg::op_swreset,
            lcd_pkg::op_sleep_in,
            lcd_pkg::op_sleep_out,
            lcd_pkg::op_disp_off,
            lcd_pkg::op_disp_on: begin
                param_count = 3'd0;  // command byte only
            end
            default: begin
                param_count = override_capped;
            end
        endcase
    end

    // panel needs settle time after these
    always_comb begin
        case (opcode)
            lcd_pkg::op_swreset,
            lcd_pkg::op_sleep_in,
            lcd_pkg::op_sleep_out: pause = 1'b1;
            default:               pause = 1'b0;
        endcase
    end

endmodule

/* hw/lcd_mmio_regs.sv */
// cpu write port and transfer staging
`timescale 1ns/10ps

module lcd_mmio_regs (
    input  logic               clk,
    input  logic               nrst,
    input  lcd_pkg::mmio_word_u wdata,
    input  logic               wr_cmd,
    input  logic               wr_par,
    output logic               busy,
    output lcd_pkg::lcd_xfer_t xfer,
    output logic               xfer_valid,
    input  logic               xfer_ready,
    input  logic               xfer_done
);

    typedef enum logic [1:0] {
        rg_idle,  // waiting for a command word
        rg_cmd,   // command held, waiting for parameters
        rg_pend   // transfer handed off or waiting for the sequencer
    } reg_state_t;

    reg_state_t state;

    logic [2:0] tbl_count;
    logic       tbl_pause;
    logic       cmd_accept;
    logic       par_accept;

    lcd_cmd_table i_table (
        .opcode         (wdata.cmd.opcode),
        .count_override (wdata.cmd.count_override),
        .param_count    (tbl_count),
        .pause          (tbl_pause)
    );

    // out-of-order or busy strobes fall through here
    assign cmd_accept = wr_cmd && !busy && (state == rg_idle);
    assign par_accept = wr_par && !busy && (state == rg_cmd);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state      <= rg_idle;
            busy       <= 1'b0;
            xfer_valid <= 1'b0;
        end else begin
            case (state)
                rg_idle: begin
                    if (cmd_accept) begin
                        state <= rg_cmd;
                    end
                end
                rg_cmd: begin
                    if (par_accept) begin
                        state      <= rg_pend;
                        busy       <= 1'b1;
                        xfer_valid <= 1'b1;
                    end
                end
                rg_pend: begin
                    if (xfer_valid && xfer_ready) begin
                        xfer_valid <= 1'b0;  // sequencer took it
                    end
                    if (xfer_done) begin
                        state <= rg_idle;
                        busy  <= 1'b0;
                    end
                end
                default: begin
                    state <= rg_idle;
                end
            endcase
        end
    end

    // transfer contents, held stable while valid
    always_ff @(posedge clk) begin
        if (cmd_accept) begin
            xfer.opcode      <= wdata.cmd.opcode;
            xfer.param_count <= tbl_count;
            xfer.pause       <= tbl_pause;
        end
        if (par_accept) begin
            xfer.params <= wdata.par;
        end
    end

endmodule

/* hw/lcd_bus_sequencer.sv */
// 8080 style write sequencer for the panel bus
`timescale 1ns/10ps

module lcd_bus_sequencer (
    input  logic               clk,
    input  logic               nrst,
    input  lcd_pkg::lcd_xfer_t xfer,
    input  logic               xfer_valid,
    output logic               xfer_ready,
    output logic               xfer_done,
    output lcd_pkg::lcd_bus_t  bus
);

    typedef enum logic [2:0] {
        st_idle,
        st_setup,    // data and dcx valid, wrx low
        st_strobe,   // wrx high, panel latches on the rising edge
        st_release,  // csx back high after the last byte
        st_pause     // settle time with csx high
    } seq_state_t;

    seq_state_t state;

    lcd_pkg::lcd_xfer_t          xfer_q;
    logic [2:0]                  byte_cnt;   // parameter bytes sent so far
    logic [lcd_pkg::pause_w-1:0] pause_cnt;

    logic take;
    logic last_byte;
    logic pause_end;

    assign take      = xfer_valid && xfer_ready;
    assign last_byte = (byte_cnt == xfer_q.param_count);
    assign pause_end = (pause_cnt == lcd_pkg::pause_cycles);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state      <= st_idle;
            xfer_ready <= 1'b1;
            xfer_done  <= 1'b0;
            byte_cnt   <= 3'd0;
            pause_cnt  <= '0;
            bus.data   <= 8'h00;
            bus.csx    <= 1'b1;
            bus.dcx    <= 1'b0;
            bus.wrx    <= 1'b0;
            bus.rdx    <= 1'b1;
        end else begin
            xfer_done <= 1'b0;  // single cycle pulse
            bus.rdx   <= 1'b1;  // reads are never issued
            case (state)
                st_idle: begin
                    if (take) begin
                        // command byte goes out right away
                        state      <= st_setup;
                        xfer_ready <= 1'b0;
                        byte_cnt   <= 3'd0;
                        bus.data   <= xfer.opcode;
                        bus.csx    <= 1'b0;
                        bus.dcx    <= 1'b0;
                        bus.wrx    <= 1'b0;
                    end
                end
                st_setup: begin
                    state   <= st_strobe;
                    bus.wrx <= 1'b1;
                end
                st_strobe: begin
                    if (last_byte) begin
                        state   <= st_release;
                        bus.csx <= 1'b1;
                        bus.wrx <= 1'b0;
                    end else begin
                        state    <= st_setup;
                        byte_cnt <= byte_cnt + 3'd1;
                        bus.data <= xfer_q.params[31:24];  // msb first
                        bus.dcx  <= 1'b1;
                        bus.wrx  <= 1'b0;
                    end
                end
                st_release: begin
                    bus.dcx <= 1'b0;
                    if (xfer_q.pause) begin
                        state     <= st_pause;
                        pause_cnt <= lcd_pkg::pause_w'(1);
                    end else begin
                        state      <= st_idle;
                        xfer_done  <= 1'b1;
                        xfer_ready <= 1'b1;
                    end
                end
                st_pause: begin
                    if (pause_end) begin
                        state      <= st_idle;
                        xfer_done  <= 1'b1;
                        xfer_ready <= 1'b1;
                    end else begin
                        pause_cnt <= pause_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // captured transfer, parameters shift out a byte at a time
    always_ff @(posedge clk) begin
        if (state == st_idle && take) begin
            xfer_q <= xfer;
        end else if (state == st_strobe && !last_byte) begin
            xfer_q.params <= {xfer_q.params[23:0], 8'h00};
        end
    end

endmodule

/* hw/lcd_ctrl_top.sv */
// display controller top level
`timescale 1ns/10ps

module lcd_ctrl_top (
    input  logic                clk,
    input  logic                nrst,
    input  lcd_pkg::mmio_word_u wdata,
    input  logic                wr_cmd,
    input  logic                wr_par,
    output logic                busy,
    output lcd_pkg::lcd_bus_t   bus
);

    lcd_pkg::lcd_xfer_t xfer;
    logic               xfer_valid;
    logic               xfer_ready;
    logic               xfer_done;

    // cpu side register front end
    lcd_mmio_regs i_regs (
        .clk        (clk),
        .nrst       (nrst),
        .wdata      (wdata),
        .wr_cmd     (wr_cmd),
        .wr_par     (wr_par),
        .busy       (busy),
        .xfer       (xfer),
        .xfer_valid (xfer_valid),
        .xfer_ready (xfer_ready),
        .xfer_done  (xfer_done)
    );

    // panel side byte sequencer
    lcd_bus_sequencer i_seq (
        .clk        (clk),
        .nrst       (nrst),
        .xfer       (xfer),
        .xfer_valid (xfer_valid),
        .xfer_ready (xfer_ready),
        .xfer_done  (xfer_done),
        .bus        (bus)
    );

endmodule

/* test/lcd_panel_model.sv */
// passive panel on the 8080 write bus
`timescale 1ns/10ps

module lcd_panel_model (
    input logic              clk,
    input logic              nrst,
    input lcd_pkg::lcd_bus_t bus,
    input logic              busy
);

    logic [8:0]  byte_log [0:255];  // {dcx, data} per latched byte
    int unsigned n_bytes = 0;
    int unsigned frame_errs = 0;    // bytes latched outside a csx-low, busy-high frame
    int unsigned hi_cycles;         // csx-high cycles at the tail of the last transfer
    logic        seen_low;          // csx went low in this transfer
    logic        wrx;

    assign wrx = bus.wrx;

    // panel latches on the rising edge of wrx
    always @(posedge wrx) begin
        if (n_bytes < 256) begin
            byte_log[n_bytes] <= {bus.dcx, bus.data};
        end
        n_bytes <= n_bytes + 1;
        if (bus.csx || !busy) begin
            frame_errs <= frame_errs + 1;
        end
    end

    always @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            seen_low  <= 1'b0;
            hi_cycles <= 0;
        end else if (!busy) begin
            seen_low <= 1'b0;  // count holds until the next transfer
        end else if (!bus.csx && !seen_low) begin
            seen_low  <= 1'b1;
            hi_cycles <= 0;
        end else if (bus.csx && seen_low) begin
            hi_cycles <= hi_cycles + 1;  // release and settle time
        end
    end

endmodule

/* test/tb_lcd_ctrl.sv */
// display controller testbench
`timescale 1ns/10ps

module tb_lcd_ctrl;

    localparam int clk_period  = 100;
    localparam int drive_delay = 5;
    localparam int n_rows      = 18;
    localparam int pause_len   = int'(lcd_pkg::pause_cycles);
    localparam int wd_cycles   = n_rows * (2 * 5 + 1 + pause_len + 10) + 20;

    logic                clk;
    logic                nrst;
    lcd_pkg::mmio_word_u wdata;
    logic                wr_cmd;
    logic                wr_par;
    logic                busy;
    lcd_pkg::lcd_bus_t   bus;

    string       t_name  [0:n_rows-1];
    logic [31:0] t_cmd   [0:n_rows-1];
    logic [31:0] t_par   [0:n_rows-1];
    int          t_cnt   [0:n_rows-1];       // parameter bytes
    logic [8:0]  t_bytes [0:n_rows-1][0:4];  // {dcx, data} with the command first
    logic        t_pause [0:n_rows-1];
    int          t_mode  [0:n_rows-1];       // 1 busy strobes, 2 lone wr_par, 3 two commands

    int          n_used;
    int          errors;
    int          checks;
    logic [31:0] lfsr;

    lcd_ctrl_top i_dut (
        .clk    (clk),
        .nrst   (nrst),
        .wdata  (wdata),
        .wr_cmd (wr_cmd),
        .wr_par (wr_par),
        .busy   (busy),
        .bus    (bus)
    );

    lcd_panel_model i_panel (
        .clk  (clk),
        .nrst (nrst),
        .bus  (bus),
        .busy (busy)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
        end
        return n;
    endfunction

    task automatic rand_word(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    // expected stream is the opcode, then the top cnt bytes of the word
    task automatic add_row(input string name, input logic [31:0] cmd, input int cnt,
                           input logic pause, input int mode);
        logic [31:0] par;
        rand_word(par);
        t_name[n_used]     = name;
        t_cmd[n_used]      = cmd;
        t_par[n_used]      = par;
        t_cnt[n_used]      = cnt;
        t_pause[n_used]    = pause;
        t_mode[n_used]     = mode;
        t_bytes[n_used][0] = {1'b0, cmd[7:0]};
        for (int k = 1; k <= 4; k++) begin
            t_bytes[n_used][k] = {1'b1, par[39 - 8 * k -: 8]};
        end
        n_used++;
    endtask

    task automatic build_table();
        add_row("caset", {24'h0, lcd_pkg::op_caset}, 4, 1'b0, 0);
        add_row("paset", {20'h0, 4'h1, lcd_pkg::op_paset}, 4, 1'b0, 0);  // override unused
        add_row("ramwr", {24'h0, lcd_pkg::op_ramwr}, 2, 1'b0, 0);
        add_row("ramrd", {24'h0, lcd_pkg::op_ramrd}, 2, 1'b0, 0);
        add_row("madctl", {24'h0, lcd_pkg::op_madctl}, 1, 1'b0, 0);
        add_row("pixfmt", {24'h0, lcd_pkg::op_pixfmt}, 1, 1'b0, 0);
        add_row("disp_on", {20'h0, 4'hf, lcd_pkg::op_disp_on}, 0, 1'b0, 0);
        add_row("disp_off", {24'h0, lcd_pkg::op_disp_off}, 0, 1'b0, 0);
        add_row("nop", {24'h0, lcd_pkg::op_nop}, 0, 1'b0, 0);
        add_row("unknown_ovr3", 32'h0000_03c0, 3, 1'b0, 0);
        add_row("unknown_ovr0", 32'h0000_00c1, 0, 1'b0, 0);
        add_row("unknown_ovr9", 32'h0000_09c2, 4, 1'b0, 0);  // capped at four
        add_row("swreset", {24'h0, lcd_pkg::op_swreset}, 0, 1'b1, 0);
        add_row("sleep_in", {24'h0, lcd_pkg::op_sleep_in}, 0, 1'b1, 0);
        add_row("sleep_out", {24'h0, lcd_pkg::op_sleep_out}, 0, 1'b1, 0);
        add_row("busy_strobes", {24'h0, lcd_pkg::op_caset}, 4, 1'b0, 1);
        add_row("lone_par", {24'h0, lcd_pkg::op_madctl}, 1, 1'b0, 2);
        add_row("double_cmd", {24'h0, lcd_pkg::op_ramwr}, 2, 1'b0, 3);
    endtask

    // one cycle strobe driven just after the rising edge
    task automatic cpu_write(input logic [31:0] w, input logic is_cmd);
        @(posedge clk);
        #drive_delay;
        wdata  = w;
        wr_cmd = is_cmd;
        wr_par = !is_cmd;
        @(posedge clk);
        #drive_delay;
        wr_cmd = 1'b0;
        wr_par = 1'b0;
    endtask

    task automatic run_row(input int r);
        logic [31:0] junk;
        int          first;
        time         t_rise;
        int          high_cycles;
        if (t_mode[r] == 2) begin
            first = i_panel.n_bytes;
            rand_word(junk);
            cpu_write(junk, 1'b0);
            repeat (4) @(posedge clk);
            #drive_delay;
            check_val($sformatf("%s no bytes", t_name[r]), first, i_panel.n_bytes);
            check_val($sformatf("%s busy", t_name[r]), 0, busy);
            check_val($sformatf("%s csx", t_name[r]), 1, bus.csx);
        end
        first = i_panel.n_bytes;
        cpu_write(t_cmd[r], 1'b1);
        if (t_mode[r] == 3) begin
            cpu_write(32'h0000_0036, 1'b1);  // a command is already held
        end
        cpu_write(t_par[r], 1'b0);
        t_rise = $time;
        check_val($sformatf("%s busy rise", t_name[r]), 1, busy);
        if (t_mode[r] == 1) begin
            cpu_write(32'h0000_003a, 1'b1);
            cpu_write(~t_par[r], 1'b0);
        end
        while (busy) begin
            @(posedge clk);
            #drive_delay;
        end
        // one cycle to handshake plus 2(n+1)+1 to done plus one for busy to fall
        high_cycles = int'(($time - t_rise) / clk_period);
        check_val($sformatf("%s busy cycles", t_name[r]),
                  2 * t_cnt[r] + 5 + (t_pause[r] ? pause_len : 0), high_cycles);
        check_val($sformatf("%s byte count", t_name[r]), t_cnt[r] + 1,
                  i_panel.n_bytes - first);
        for (int k = 0; k <= t_cnt[r]; k++) begin
            check_val($sformatf("%s byte %0d", t_name[r], k), t_bytes[r][k],
                      i_panel.byte_log[first + k]);
        end
        check_val($sformatf("%s pause", t_name[r]), t_pause[r],
                  i_panel.hi_cycles >= pause_len);
        check_val($sformatf("%s framing", t_name[r]), 0, i_panel.frame_errs);
        if (t_mode[r] == 1) begin
            // strobes seen while busy must not start a second transfer
            first = i_panel.n_bytes;
            repeat (4) @(posedge clk);
            #drive_delay;
            check_val($sformatf("%s no late bytes", t_name[r]), first, i_panel.n_bytes);
            check_val($sformatf("%s stays idle", t_name[r]), 0, busy);
        end
    endtask

    initial begin
        clk    = 1'b0;
        nrst   = 1'b0;
        wdata  = '0;
        wr_cmd = 1'b0;
        wr_par = 1'b0;
        errors = 0;
        checks = 0;
        n_used = 0;
        lfsr   = 32'd81;
        build_table();
        repeat (3) @(posedge clk);
        #drive_delay;
        nrst = 1'b1;
        check_val("reset csx", 1, bus.csx);
        check_val("reset wrx", 0, bus.wrx);
        check_val("reset rdx", 1, bus.rdx);
        check_val("reset busy", 0, busy);
        check_val("reset bytes", 0, i_panel.n_bytes);
        for (int r = 0; r < n_used; r++) begin
            run_row(r);
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // run limit scaled by the table length
    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("timeout waiting for busy to fall");
        $display("Simulation failed");
        $finish;
    end

endmodule

/* filelist.f */
hw/lcd_pkg.sv
hw/lcd_cmd_table.sv
hw/lcd_mmio_regs.sv
hw/lcd_bus_sequencer.sv
hw/lcd_ctrl_top.sv
test/lcd_panel_model.sv
test/tb_lcd_ctrl.sv
